/* verilog/adc_pkg.sv */
// adc capture package: widths, fifo depth, lane and frame types, deserializer phase enum

package adc_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int sample_width  = 8;              // bits per adc sample
  localparam int num_channels  = 4;              // di_d, di, dq_d, dq
  localparam int deser_ratio   = 4;              // samples per channel per frame
  localparam int num_sync_bits = deser_ratio;    // one sync bit per slot
  localparam int num_ovr_bits  = 2;              // first half, second half

  localparam int chan_bits  = deser_ratio * sample_width;  // 32, one channel in a frame
  localparam int data_bits  = num_channels * chan_bits;    // 128
  localparam int frame_width = num_sync_bits + num_ovr_bits + data_bits;  // 134

  localparam int fifo_depth      = 8;  // frames
  localparam int fifo_addr_width = 3;  // log2 of fifo_depth

  // extra pipeline stage between deserializer and fifo, helps timing
  localparam bit extra_reg_en = 1'b1;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [sample_width-1:0] adc_sample_t;

  // one channel of a frame, index 0 oldest, newest at the top bits
  typedef adc_sample_t [deser_ratio-1:0] adc_chan_t;

  // what the adc presents every adc_clk
  typedef struct packed {
    adc_sample_t di_d;
    adc_sample_t di;
    adc_sample_t dq_d;
    adc_sample_t dq;
    logic        sync;       // level, sampled once per slot
    logic        overrange;  // level
  } adc_lanes_t;             // 34 bits

  // flat fifo word, top down: sync[3:0], ovr[1:0], dq, dq_d, di, di_d
  typedef logic [frame_width-1:0] adc_fifo_word_t;

  // user side view, every array reads left to right in arrival order
  typedef struct packed {
    adc_sample_t [0:deser_ratio-1] di_d;
    adc_sample_t [0:deser_ratio-1] di;
    adc_sample_t [0:deser_ratio-1] dq_d;
    adc_sample_t [0:deser_ratio-1] dq;
    logic [0:num_sync_bits-1]      sync;       // [0] = slot 0
    logic [0:num_ovr_bits-1]       overrange;  // [0] = first half
  } adc_user_frame_t;                          // 134 bits

  // sample slot within a frame
  typedef enum logic [1:0] {
    ph0,
    ph1,
    ph2,
    ph3
  } deser_phase_e;

endpackage

/* verilog/adc_sample_deserializer.sv */
// adc_sample_deserializer: 4:1 gather of the four adc channels into one fifo frame word

`timescale 1ns/100ps

module adc_sample_deserializer (
  input  logic                    adc_clk,
  input  logic                    dcm_reset,
  input  logic                    ctrl_reset,  // restarts slot counting
  input  adc_pkg::adc_lanes_t     lanes,
  output adc_pkg::adc_fifo_word_t frame_word,
  output logic                    frame_wr     // one cycle per frame
);

  adc_pkg::deser_phase_e phase;  // slot being captured this edge

  adc_pkg::adc_sample_t [adc_pkg::num_channels-1:0] cur;  // this cycle, [0] = di_d
  // last three samples per channel, newest at top
  adc_pkg::adc_sample_t [adc_pkg::deser_ratio-2:0] samp_sr [adc_pkg::num_channels];
  logic [adc_pkg::deser_ratio-2:0] sync_sr;
  logic ovr_first;   // or of overrange over slots 0,1
  logic ovr_second;  // slot 2 only, slot 3 added at pack time

  adc_pkg::adc_chan_t [adc_pkg::num_channels-1:0] chans;  // full frame incl current sample

  adc_pkg::adc_fifo_word_t word_d;
  logic                    wr_d;

  assign cur = {lanes.dq, lanes.dq_d, lanes.di, lanes.di_d};

  always_comb begin
    for (int c = 0; c < adc_pkg::num_channels; c++) begin
      chans[c] = {cur[c], samp_sr[c]};  // slot 3 on top
    end
  end

  // ----------------------------------------
  // slot counter
  // ----------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset || ctrl_reset) begin
      phase <= adc_pkg::ph0;  // first edge after release is slot 0
    end else begin
      unique case (phase)
        adc_pkg::ph0: phase <= adc_pkg::ph1;
        adc_pkg::ph1: phase <= adc_pkg::ph2;
        adc_pkg::ph2: phase <= adc_pkg::ph3;
        default:      phase <= adc_pkg::ph0;
      endcase
    end
  end

  // ----------------------------------------
  // sample and flag capture
  // ----------------------------------------
  // shift every cycle, slot alignment comes from phase at pack time
  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < adc_pkg::num_channels; c++) begin
      samp_sr[c] <= {cur[c], samp_sr[c][adc_pkg::deser_ratio-2:1]};
    end
    sync_sr <= {lanes.sync, sync_sr[adc_pkg::deser_ratio-2:1]};

    unique case (phase)
      adc_pkg::ph0: ovr_first  <= lanes.overrange;              // start first half
      adc_pkg::ph1: ovr_first  <= ovr_first | lanes.overrange;
      adc_pkg::ph2: ovr_second <= lanes.overrange;              // start second half
      default:      ovr_second <= ovr_second;                   // ph3 folded in below
    endcase
  end

  // pack on the slot 3 edge
  always_ff @(posedge adc_clk) begin
    if (phase == adc_pkg::ph3) begin
      word_d <= {lanes.sync, sync_sr, ovr_second | lanes.overrange, ovr_first, chans};
    end
  end

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_d <= 1'b0;
    end else begin
      wr_d <= (phase == adc_pkg::ph3) && !ctrl_reset;  // no frame if realigning
    end
  end

  // ----------------------------------------
  // optional timing register
  // ----------------------------------------
  generate
    if (adc_pkg::extra_reg_en) begin : g_extra_reg
      adc_pkg::adc_fifo_word_t word_q;
      logic                    wr_q;

      always_ff @(posedge adc_clk) begin
        word_q <= word_d;  // payload, no reset
        if (dcm_reset) begin
          wr_q <= 1'b0;
        end else begin
          wr_q <= wr_d;
        end
      end

      assign frame_word = word_q;
      assign frame_wr   = wr_q;
    end else begin : g_no_extra_reg
      assign frame_word = word_d;
      assign frame_wr   = wr_d;
    end
  endgenerate

endmodule

/* verilog/adc_frame_fifo.sv */
// adc_frame_fifo: single clock frame fifo with registered read data and sticky overflow

`timescale 1ns/100ps

module adc_frame_fifo (
  input  logic                    adc_clk,
  input  logic                    dcm_reset,
  input  logic                    wr_en,
  input  adc_pkg::adc_fifo_word_t wr_word,
  input  logic                    rd_en,
  output adc_pkg::adc_fifo_word_t rd_word,   // valid the cycle after the read edge
  output logic                    empty,
  output logic                    full,
  output logic                    overflow   // sticky until dcm_reset
);

  adc_pkg::adc_fifo_word_t mem [adc_pkg::fifo_depth];

  logic [adc_pkg::fifo_addr_width-1:0] wr_ptr;
  logic [adc_pkg::fifo_addr_width-1:0] rd_ptr;
  logic [adc_pkg::fifo_addr_width:0]   count;   // 0..fifo_depth

  logic wr_ok;
  logic rd_ok;

  assign empty = (count == '0);
  assign full  = (count == (adc_pkg::fifo_addr_width + 1)'(adc_pkg::fifo_depth));

  assign wr_ok = wr_en && !full;   // adc cannot stall, frame is lost
  assign rd_ok = rd_en && !empty;  // read on empty ignored

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge adc_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_word;
    end
    if (rd_ok) begin
      rd_word <= mem[rd_ptr];  // holds last word otherwise
    end
  end

  // ----------------------------------------
  // pointers, count, flags
  // ----------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      unique case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase

      if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

/* verilog/adc_user_unpacker.sv */
// adc_user_unpacker: fifo read control and reorder of frame words into arrival order

`timescale 1ns/100ps

module adc_user_unpacker (
  input  logic                     adc_clk,
  input  logic                     dcm_reset,
  input  logic                     user_hold,  // high = leave frames in the fifo
  input  logic                     empty,
  input  adc_pkg::adc_fifo_word_t  rd_word,
  output logic                     fifo_rd,
  output adc_pkg::adc_user_frame_t user_frame,
  output logic                     user_data_valid
);

  logic rd_pending;  // rd_word holds a fresh frame this cycle

  // flat newest-on-top word to arrival ordered user view
  function automatic adc_pkg::adc_user_frame_t unpack_frame(
    input adc_pkg::adc_fifo_word_t w
  );
    adc_pkg::adc_user_frame_t                       uf;
    adc_pkg::adc_chan_t [adc_pkg::num_channels-1:0] chans;
    chans = w[adc_pkg::data_bits-1:0];  // [0] = di_d ... [3] = dq
    for (int k = 0; k < adc_pkg::deser_ratio; k++) begin
      uf.di_d[k] = chans[0][k];  // slot k
      uf.di[k]   = chans[1][k];
      uf.dq_d[k] = chans[2][k];
      uf.dq[k]   = chans[3][k];
      uf.sync[k] = w[adc_pkg::data_bits + adc_pkg::num_ovr_bits + k];
    end
    for (int h = 0; h < adc_pkg::num_ovr_bits; h++) begin
      uf.overrange[h] = w[adc_pkg::data_bits + h];
    end
    return uf;
  endfunction

  // read as soon as something is there, one frame per cycle max
  assign fifo_rd = !empty && !user_hold;

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      rd_pending      <= 1'b0;
      user_data_valid <= 1'b0;
    end else begin
      rd_pending      <= fifo_rd;
      user_data_valid <= rd_pending;  // single cycle strobe per frame
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rd_pending) begin
      user_frame <= unpack_frame(rd_word);  // held between frames
    end
  end

endmodule

/* verilog/adc_capture_top.sv */
// adc_capture_top: deserializer, frame fifo and user unpacker for the four channel adc

`timescale 1ns/100ps

module adc_capture_top (
  input  logic                     adc_clk,
  input  logic                     dcm_reset,
  input  logic                     ctrl_reset,
  input  adc_pkg::adc_lanes_t      lanes,
  input  logic                     user_hold,
  output logic                     adc_rst,          // to the adc
  output adc_pkg::adc_user_frame_t user_frame,
  output logic                     user_data_valid,
  output logic                     fifo_overflow
);

  adc_pkg::adc_fifo_word_t frame_word;
  logic                    frame_wr;
  adc_pkg::adc_fifo_word_t rd_word;
  logic                    fifo_rd;
  logic                    fifo_empty;

  assign adc_rst = ctrl_reset;

  // ----------------------------------------
  // adc side
  // ----------------------------------------
  adc_sample_deserializer u_deser (
    .adc_clk    (adc_clk),
    .dcm_reset  (dcm_reset),
    .ctrl_reset (ctrl_reset),
    .lanes      (lanes),
    .frame_word (frame_word),
    .frame_wr   (frame_wr)
  );

  adc_frame_fifo u_fifo (
    .adc_clk   (adc_clk),
    .dcm_reset (dcm_reset),
    .wr_en     (frame_wr),
    .wr_word   (frame_word),
    .rd_en     (fifo_rd),
    .rd_word   (rd_word),
    .empty     (fifo_empty),
    .full      (),
    .overflow  (fifo_overflow)
  );

  // ----------------------------------------
  // user side
  // ----------------------------------------
  adc_user_unpacker u_unpack (
    .adc_clk         (adc_clk),
    .dcm_reset       (dcm_reset),
    .user_hold       (user_hold),
    .empty           (fifo_empty),
    .rd_word         (rd_word),
    .fifo_rd         (fifo_rd),
    .user_frame      (user_frame),
    .user_data_valid (user_data_valid)
  );

endmodule

/* sim/adc_capture_tests.svh */
// directed tests: reset state, stream order and latency, flags, back-pressure, overflow, realign

// ----------------------------------------
// reset and pass-through
// ----------------------------------------
task automatic test_reset_state();
  check_word("user_data_valid", 32'(user_data_valid), 32'h0);
  check_word("fifo_overflow", 32'(fifo_overflow), 32'h0);
  @(negedge adc_clk);
  ctrl_reset = 1'b0;  // one cycle only, no frame completes
  #1;
  check_word("adc_rst", 32'(adc_rst), 32'h0);
  @(negedge adc_clk);
  ctrl_reset = 1'b1;
  #1;
  check_word("adc_rst", 32'(adc_rst), 32'h1);
  wait_drain();  // nothing may come out
endtask

// back to back frames, every one timed
task automatic test_stream_order();
  repeat (5) begin
    send_frame(4'($urandom()), 4'($urandom()), 1'b1, 1'b1);
  end
  end_stream();
  wait_drain();
endtask

// one flag per slot, overrange in each half
task automatic test_flags();
  send_frame(4'b0001, 4'b0001, 1'b1, 1'b1);  // slot 0, first half
  send_frame(4'b0010, 4'b0010, 1'b1, 1'b1);
  send_frame(4'b0100, 4'b0100, 1'b1, 1'b1);  // second half
  send_frame(4'b1000, 4'b1000, 1'b1, 1'b1);  // last slot
  send_frame(4'b1010, 4'b1111, 1'b1, 1'b1);
  send_frame(4'b0101, 4'b0000, 1'b1, 1'b1);
  end_stream();
  wait_drain();
endtask

// ----------------------------------------
// fifo fill
// ----------------------------------------
task automatic test_backpressure();
  user_hold = 1'b1;
  repeat (6) begin
    send_frame(4'($urandom()), 4'($urandom()), 1'b1, 1'b0);
  end
  end_stream();
  repeat (3) @(negedge adc_clk);  // last write lands
  user_hold = 1'b0;
  wait_drain();
  check_word("fifo_overflow", 32'(fifo_overflow), 32'h0);
endtask

task automatic test_overflow();
  user_hold = 1'b1;
  for (int f = 0; f < adc_pkg::fifo_depth + 2; f++) begin
    send_frame(4'($urandom()), 4'($urandom()), f < adc_pkg::fifo_depth, 1'b0);
  end
  end_stream();
  repeat (3) @(negedge adc_clk);
  check_word("fifo_overflow", 32'(fifo_overflow), 32'h1);
  user_hold = 1'b0;
  wait_drain();  // only the first fifo_depth frames
  check_word("fifo_overflow", 32'(fifo_overflow), 32'h1);  // sticky
  apply_reset();
  check_word("fifo_overflow", 32'(fifo_overflow), 32'h0);
endtask

// ctrl_reset in the middle of a frame
task automatic test_realign();
  send_frame(4'($urandom()), 4'($urandom()), 1'b1, 1'b1);
  repeat (2) begin
    @(negedge adc_clk);
    lanes      = random_lanes(1'b1, 1'b1);  // partial frame, dropped
    ctrl_reset = 1'b0;
  end
  @(negedge adc_clk);
  ctrl_reset = 1'b1;
  send_frame(4'b0001, 4'b0000, 1'b1, 1'b1);  // slot 0 right after release
  end_stream();
  wait_drain();
endtask

/* sim/adc_capture_tb.sv */
// adc capture testbench: clock, reset, dut, frame scoreboard, checking helpers, timeout, report

`timescale 1ns/100ps

module adc_capture_tb;

  // ----------------------------------------
  // run length
  // ----------------------------------------
  localparam int reset_cycles  = 4;
  localparam int valid_latency = 4;   // slot 3 edge to user_data_valid
  localparam int drain_limit   = 40;  // cycles allowed for expected frames to come out
  localparam int num_tests     = 6;
  localparam int num_frames    = 29;  // full frames sent over all tests
  localparam int timeout_cycles = 3 * reset_cycles + num_frames * adc_pkg::deser_ratio
                                  + num_tests * (drain_limit + 8) + 100;

  logic                     adc_clk;
  logic                     dcm_reset;
  logic                     ctrl_reset;
  adc_pkg::adc_lanes_t      lanes;
  logic                     user_hold;
  logic                     adc_rst;
  adc_pkg::adc_user_frame_t user_frame;
  logic                     user_data_valid;
  logic                     fifo_overflow;

  int          cycle_cnt   = 0;  // rising edges so far
  int          err_count   = 0;
  int          check_count = 0;
  int unsigned first_rand;

  adc_pkg::adc_user_frame_t exp_frames [$];  // scoreboard, oldest first
  int                       exp_due    [$];  // cycle of valid, 0 = untimed

  adc_capture_top u_adc_capture_top (
    .adc_clk         (adc_clk),
    .dcm_reset       (dcm_reset),
    .ctrl_reset      (ctrl_reset),
    .lanes           (lanes),
    .user_hold       (user_hold),
    .adc_rst         (adc_rst),
    .user_frame      (user_frame),
    .user_data_valid (user_data_valid),
    .fifo_overflow   (fifo_overflow)
  );

  always #5 adc_clk = ~adc_clk;  // 10 ns period

  // cycle count and hang guard
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout after %0d cycles, checks %0d, errors %0d",
               cycle_cnt, check_count, err_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // checking helpers
  // ----------------------------------------
  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp_val);
    check_count++;
    assert (got === exp_val) else begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp_val);
      err_count++;
    end
  endtask

  // one user frame against the scoreboard head
  task automatic check_frame_out();
    adc_pkg::adc_user_frame_t exp_frame;
    int                       due;
    check_count++;
    assert (exp_frames.size() > 0) else begin
      $display("frame came out at cycle %0d with none expected", cycle_cnt);
      err_count++;
    end
    if (exp_frames.size() > 0) begin
      exp_frame = exp_frames.pop_front();
      due       = exp_due.pop_front();
      check_word("user_frame.di_d", user_frame.di_d, exp_frame.di_d);
      check_word("user_frame.di", user_frame.di, exp_frame.di);
      check_word("user_frame.dq_d", user_frame.dq_d, exp_frame.dq_d);
      check_word("user_frame.dq", user_frame.dq, exp_frame.dq);
      check_word("user_frame.sync", 32'(user_frame.sync), 32'(exp_frame.sync));
      check_word("user_frame.overrange", 32'(user_frame.overrange),
                 32'(exp_frame.overrange));
      if (due != 0) begin
        check_count++;
        assert (cycle_cnt == due) else begin
          $display("user_data_valid came at cycle %0d instead of cycle %0d", cycle_cnt, due);
          err_count++;
        end
      end
    end
  endtask

  // outputs are stable on the falling edge
  always @(negedge adc_clk) begin
    if (!dcm_reset && user_data_valid) begin
      check_frame_out();
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic adc_pkg::adc_lanes_t random_lanes(input logic sync, input logic ovr);
    adc_pkg::adc_lanes_t l;
    l.di_d      = 8'($urandom());
    l.di        = 8'($urandom());
    l.dq_d      = 8'($urandom());
    l.dq        = 8'($urandom());
    l.sync      = sync;
    l.overrange = ovr;
    return l;
  endfunction

  // four slots of random samples, bit k of each pattern goes to slot k
  task automatic send_frame(input logic [3:0] sync_pat, input logic [3:0] ovr_pat,
                            input bit push, input bit timed);
    adc_pkg::adc_user_frame_t exp_frame;
    adc_pkg::adc_lanes_t      l;
    bit [1:0]                 slot;
    int                       due;
    due = 0;
    for (int k = 0; k < adc_pkg::deser_ratio; k++) begin
      slot = 2'(k);
      @(negedge adc_clk);
      l          = random_lanes(sync_pat[slot], ovr_pat[slot]);
      lanes      = l;
      ctrl_reset = 1'b0;
      exp_frame.di_d[slot] = l.di_d;  // arrival order
      exp_frame.di[slot]   = l.di;
      exp_frame.dq_d[slot] = l.dq_d;
      exp_frame.dq[slot]   = l.dq;
      exp_frame.sync[slot] = l.sync;
    end
    exp_frame.overrange[0] = ovr_pat[0] | ovr_pat[1];  // first half
    exp_frame.overrange[1] = ovr_pat[2] | ovr_pat[3];  // second half
    if (timed) begin
      due = cycle_cnt + 1 + valid_latency;  // next edge captures slot 3
    end
    if (push) begin
      exp_frames.push_back(exp_frame);
      exp_due.push_back(due);
    end
  endtask

  // ctrl_reset high keeps the slot counter at ph0, no frames
  task automatic end_stream();
    @(negedge adc_clk);
    ctrl_reset = 1'b1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_frames.size() > 0 && waited < drain_limit) begin
      @(posedge adc_clk);
      waited++;
    end
    check_count++;
    assert (exp_frames.size() == 0) else begin
      $display("%0d expected frames never came out", exp_frames.size());
      err_count++;
      exp_frames.delete();
      exp_due.delete();
    end
    repeat (4) @(negedge adc_clk);  // catches stray frames
  endtask

  task automatic apply_reset();
    dcm_reset = 1'b1;
    repeat (reset_cycles) @(posedge adc_clk);
    @(negedge adc_clk);
    dcm_reset = 1'b0;
  endtask

  `include "adc_capture_tests.svh"

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    adc_clk    = 1'b0;
    dcm_reset  = 1'b1;
    ctrl_reset = 1'b1;  // idle between streams
    user_hold  = 1'b0;
    lanes      = '0;
    first_rand = $urandom(63);  // seeds the run
    apply_reset();

    test_reset_state();
    test_stream_order();
    test_flags();
    test_backpressure();
    test_overflow();
    test_realign();

    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+sim
verilog/adc_pkg.sv
verilog/adc_sample_deserializer.sv
verilog/adc_frame_fifo.sv
verilog/adc_user_unpacker.sv
verilog/adc_capture_top.sv
sim/adc_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the adc capture testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f tb.f \
  --top-module adc_capture_tb \
  -o adc_capture_sim \
  && sim_out=$(./obj_dir/adc_capture_sim) \
  || { echo "verilator build or run failed"; exit 1; }

printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
